/* src/gd_bist_consts.svh */
// constants for the hv-side bist
// clock rate, adc width and pass window, test windows, run timeout

`ifndef GD_BIST_CONSTS_SVH
`define GD_BIST_CONSTS_SVH

// ==============================
// clock and adc
// ==============================
`define CLK_M            4            // cycles per us
`define ADC_DW           10           // adc sample width

// mid-scale pass window, both ends inclusive
`define ADC_DN_TH        504          // 0x1f8
`define ADC_UP_TH        519          // 0x207

// ==============================
// test windows in cycles
// ==============================
`define WIN_OV_CYC       (70*`CLK_M)  // 70us, 280 cycles
`define WIN_FLT_CYC      (1*`CLK_M)   // ot, desat, oc, sc
`define WIN_ADC_CYC      (4*`CLK_M)   // adc mid-scale check

// whole run limit, catches a flag that never drops
`define BIST_TIMEOUT_CYC 2000

`endif

/* src/gd_bist_pkg.sv */
// shared types of the hv-side bist
// vector typedefs, item and controller state enums
// packed structs for detector flags, adc samples and the run result

`include "gd_bist_consts.svh"

package gd_bist_pkg;

    // ==============================
    // plain vectors
    // ==============================
    typedef logic [`ADC_DW-1:0] adc_data_t;  // one adc sample
    typedef logic [5:0]         bist_vec_t;  // one bit per item, index = item code
    typedef logic [8:0]         bist_cnt_t;  // wide enough for the ov window

    // ==============================
    // state machines
    // ==============================
    // fixed test order, ITEM_END means sequence complete
    typedef enum logic [2:0] {
        ITEM_OV    = 3'd0,
        ITEM_OT    = 3'd1,
        ITEM_DESAT = 3'd2,
        ITEM_OC    = 3'd3,
        ITEM_SC    = 3'd4,
        ITEM_ADC   = 3'd5,
        ITEM_END   = 3'd6
    } bist_item_e;

    typedef enum logic [1:0] {
        ST_IDLE = 2'd0,
        ST_RUN  = 2'd1,
        ST_DONE = 2'd2
    } ctrl_state_e;

    // ==============================
    // bundles
    // ==============================
    typedef struct packed {
        logic ov;
        logic ot;
        logic desat;
        logic oc;
        logic sc;
    } hv_flags_t;

    typedef struct packed {
        adc_data_t data1;
        adc_data_t data2;
        logic      vld;    // new sample pair, one cycle
    } hv_adc_t;

    typedef struct packed {
        bist_vec_t status;
        logic      pass;
        logic      timeout;
    } bist_result_t;

endpackage

/* src/hv_flag_sync.sv */
// detector flag synchronizer and adc sample capture
// two flops per asynchronous flag, sample pair latched on its valid strobe

module hv_flag_sync (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  gd_bist_pkg::hv_flags_t i_hv_flags,
    input  gd_bist_pkg::hv_adc_t   i_hv_adc,
    output gd_bist_pkg::hv_flags_t o_flags,
    output gd_bist_pkg::hv_adc_t   o_adc
);

    gd_bist_pkg::hv_flags_t flags_meta;  // first stage, may go metastable
    gd_bist_pkg::hv_flags_t flags_sync;
    gd_bist_pkg::adc_data_t data1_q;
    gd_bist_pkg::adc_data_t data2_q;
    logic                   vld_q;

    // ==============================
    // flag synchronizer
    // ==============================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            flags_meta <= '0;
            flags_sync <= '0;
        end else begin
            flags_meta <= i_hv_flags;
            flags_sync <= flags_meta;
        end
    end

    // ==============================
    // adc capture
    // ==============================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            data1_q <= '0;
            data2_q <= '0;
            vld_q   <= 1'b0;
        end else begin
            vld_q <= i_hv_adc.vld;  // follows the data by one cycle
            if (i_hv_adc.vld) begin
                data1_q <= i_hv_adc.data1;
                data2_q <= i_hv_adc.data2;
            end
        end
    end

    assign o_flags = flags_sync;
    assign o_adc   = '{data1: data1_q, data2: data2_q, vld: vld_q};

    // held sample pair only moves on a valid strobe
    a_adc_hold: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        !i_hv_adc.vld |=> $stable({data1_q, data2_q})
    ) else $error("adc sample changed without valid");

endmodule

/* src/hv_abist.sv */
// hv analog bist sequencer
// steps ov, ot, desat, oc, sc and adc items in fixed order
// per item: stimulus window, pass capture, wait for flag release
// adc mid-scale window compare, logic bist enable at the end

`include "gd_bist_consts.svh"

module hv_abist (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  logic                   i_bist_en,
    input  logic                   i_bist_clr,
    input  gd_bist_pkg::hv_flags_t i_flags,
    input  gd_bist_pkg::hv_adc_t   i_adc,
    output gd_bist_pkg::bist_vec_t o_bist_stim,
    output gd_bist_pkg::bist_vec_t o_status,
    output logic                   o_lbist_en
);

    gd_bist_pkg::bist_item_e bist_sel;     // current item
    gd_bist_pkg::bist_cnt_t  bist_cnt;     // cycles into the window
    gd_bist_pkg::bist_cnt_t  win_len;
    gd_bist_pkg::bist_vec_t  item_hot;     // one-hot of bist_sel
    gd_bist_pkg::bist_vec_t  detect_vec;
    gd_bist_pkg::bist_vec_t  release_vec;
    logic                    adc1_ok;
    logic                    adc2_ok;
    logic                    adc_ok;
    logic                    item_act;
    logic                    in_win;
    logic                    cur_release;

    // ==============================
    // adc window compare
    // ==============================
    assign adc1_ok = (i_adc.data1 >= gd_bist_pkg::adc_data_t'(`ADC_DN_TH)) &&
                     (i_adc.data1 <= gd_bist_pkg::adc_data_t'(`ADC_UP_TH));
    assign adc2_ok = (i_adc.data2 >= gd_bist_pkg::adc_data_t'(`ADC_DN_TH)) &&
                     (i_adc.data2 <= gd_bist_pkg::adc_data_t'(`ADC_UP_TH));
    assign adc_ok  = i_adc.vld && adc1_ok && adc2_ok;  // only at a fresh sample pair

    // bit order follows the item codes
    assign detect_vec  = {adc_ok, i_flags.sc, i_flags.oc, i_flags.desat,
                          i_flags.ot, i_flags.ov};
    // adc has no flag to wait for
    assign release_vec = {1'b1, ~i_flags.sc, ~i_flags.oc, ~i_flags.desat,
                          ~i_flags.ot, ~i_flags.ov};

    // ==============================
    // item decode
    // ==============================
    always_comb begin
        case (bist_sel)
            gd_bist_pkg::ITEM_OV:  win_len = gd_bist_pkg::bist_cnt_t'(`WIN_OV_CYC);
            gd_bist_pkg::ITEM_OT,
            gd_bist_pkg::ITEM_DESAT,
            gd_bist_pkg::ITEM_OC,
            gd_bist_pkg::ITEM_SC:  win_len = gd_bist_pkg::bist_cnt_t'(`WIN_FLT_CYC);
            gd_bist_pkg::ITEM_ADC: win_len = gd_bist_pkg::bist_cnt_t'(`WIN_ADC_CYC);
            default:               win_len = '0;  // ITEM_END, nothing to run
        endcase
    end

    // the set bit shifts out at ITEM_END
    assign item_hot    = gd_bist_pkg::bist_vec_t'(6'b000001 << bist_sel);
    assign item_act    = i_bist_en && (bist_sel != gd_bist_pkg::ITEM_END);
    assign in_win      = bist_cnt < win_len;
    assign cur_release = |(release_vec & item_hot);

    // ==============================
    // selector and window counter
    // ==============================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            bist_sel <= gd_bist_pkg::ITEM_OV;
            bist_cnt <= '0;
        end else if (i_bist_clr) begin
            bist_sel <= gd_bist_pkg::ITEM_OV;  // new run starts from the top
            bist_cnt <= '0;
        end else if (item_act) begin
            if (in_win) begin
                bist_cnt <= bist_cnt + 1'b1;
            end else if (cur_release) begin
                // window over and flag back low
                bist_cnt <= '0;
                bist_sel <= gd_bist_pkg::bist_item_e'(bist_sel + 3'd1);
            end
        end
    end

    // stimulus is high for exactly win_len cycles, one cycle behind the counter
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_bist_stim <= '0;
        end else if (item_act && in_win) begin
            o_bist_stim <= item_hot;
        end else begin
            o_bist_stim <= '0;
        end
    end

    // ==============================
    // pass capture
    // ==============================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_status <= '0;
        end else if (i_bist_clr) begin
            o_status <= '0;
        end else if (item_act && in_win) begin
            o_status <= o_status | (detect_vec & item_hot);  // sticky per item
        end
    end

    // held past the run, dropped at the next start
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_lbist_en <= 1'b0;
        end else if (i_bist_clr) begin
            o_lbist_en <= 1'b0;
        end else if (i_bist_en && (bist_sel == gd_bist_pkg::ITEM_END)) begin
            o_lbist_en <= 1'b1;
        end
    end

    // ==============================
    // assertions
    // ==============================
    a_stim_onehot: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        $onehot0(o_bist_stim)
    ) else $error("more than one stimulus line high");

    a_sel_range: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        bist_sel <= gd_bist_pkg::ITEM_END
    ) else $error("item selector out of range");

    a_lbist_end: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_lbist_en |-> (bist_sel == gd_bist_pkg::ITEM_END)
    ) else $error("logic bist enabled before sequence end");

endmodule

/* src/bist_ctrl.sv */
// bist run control
// idle/run/done state machine, clear strobe and run enable
// whole-run timeout, done strobe and frozen result with pass summary

`include "gd_bist_consts.svh"

module bist_ctrl (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_bist_start,
    input  logic                      i_lbist_done,
    input  gd_bist_pkg::bist_vec_t    i_status,
    output logic                      o_bist_en,
    output logic                      o_bist_clr,
    output logic                      o_busy,
    output logic                      o_done,
    output gd_bist_pkg::bist_result_t o_result
);

    localparam int TMO_W = $clog2(`BIST_TIMEOUT_CYC);

    gd_bist_pkg::ctrl_state_e state;
    gd_bist_pkg::ctrl_state_e state_nxt;
    logic [TMO_W-1:0]         tmo_cnt;
    logic                     start_ok;
    logic                     tmo_hit;
    logic                     run_end;

    // a strobe during a run is dropped
    assign start_ok = i_bist_start && (state != gd_bist_pkg::ST_RUN);
    assign tmo_hit  = (state == gd_bist_pkg::ST_RUN) &&
                      (tmo_cnt == TMO_W'(`BIST_TIMEOUT_CYC - 1));
    assign run_end  = (state == gd_bist_pkg::ST_RUN) && (i_lbist_done || tmo_hit);

    // ==============================
    // state machine
    // ==============================
    always_comb begin
        state_nxt = state;
        case (state)
            gd_bist_pkg::ST_IDLE: if (start_ok) state_nxt = gd_bist_pkg::ST_RUN;
            gd_bist_pkg::ST_RUN:  if (run_end)  state_nxt = gd_bist_pkg::ST_DONE;
            gd_bist_pkg::ST_DONE: begin
                state_nxt = start_ok ? gd_bist_pkg::ST_RUN : gd_bist_pkg::ST_IDLE;
            end
            default:              state_nxt = gd_bist_pkg::ST_IDLE;
        endcase
    end

    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            state <= gd_bist_pkg::ST_IDLE;
        end else begin
            state <= state_nxt;
        end
    end

    // run timer, restarts with each run
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            tmo_cnt <= '0;
        end else if (start_ok) begin
            tmo_cnt <= '0;
        end else if ((state == gd_bist_pkg::ST_RUN) && !tmo_hit) begin
            tmo_cnt <= tmo_cnt + 1'b1;
        end
    end

    // ==============================
    // result
    // ==============================
    always_ff @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            o_result <= '0;
        end else if (start_ok) begin
            o_result <= '0;  // old result gone at a new start
        end else if (run_end) begin
            o_result.status  <= i_status;
            o_result.timeout <= !i_lbist_done;
            o_result.pass    <= (&i_status) && i_lbist_done;
        end
    end

    assign o_bist_clr = start_ok;
    assign o_bist_en  = (state == gd_bist_pkg::ST_RUN);  // low again on the done cycle
    assign o_busy     = (state == gd_bist_pkg::ST_RUN);
    assign o_done     = (state == gd_bist_pkg::ST_DONE);

    a_done_pulse: assert property (
        @(posedge i_clk) disable iff (!i_rst_n)
        o_done |=> !o_done
    ) else $error("done held longer than one cycle");

endmodule

/* src/hv_bist_top.sv */
// hv-side bist top level
// flag synchronizer, analog bist sequencer and run controller

module hv_bist_top (
    input  logic                      i_clk,
    input  logic                      i_rst_n,
    input  logic                      i_bist_start,
    input  gd_bist_pkg::hv_flags_t    i_hv_flags,
    input  gd_bist_pkg::hv_adc_t      i_hv_adc,
    output gd_bist_pkg::bist_vec_t    o_bist_stim,
    output logic                      o_bist_done,
    output logic                      o_bist_busy,
    output gd_bist_pkg::bist_result_t o_bist_result,
    output logic                      o_lbist_en
);

    gd_bist_pkg::hv_flags_t flags_sync;
    gd_bist_pkg::hv_adc_t   adc_sync;
    gd_bist_pkg::bist_vec_t bist_status;
    logic                   bist_en;
    logic                   bist_clr;

    hv_flag_sync u_hv_flag_sync (
        .i_clk      (i_clk),
        .i_rst_n    (i_rst_n),
        .i_hv_flags (i_hv_flags),
        .i_hv_adc   (i_hv_adc),
        .o_flags    (flags_sync),
        .o_adc      (adc_sync)
    );

    hv_abist u_hv_abist (
        .i_clk       (i_clk),
        .i_rst_n     (i_rst_n),
        .i_bist_en   (bist_en),
        .i_bist_clr  (bist_clr),
        .i_flags     (flags_sync),
        .i_adc       (adc_sync),
        .o_bist_stim (o_bist_stim),
        .o_status    (bist_status),
        .o_lbist_en  (o_lbist_en)
    );

    // sequence complete feeds the controller straight from the output
    bist_ctrl u_bist_ctrl (
        .i_clk        (i_clk),
        .i_rst_n      (i_rst_n),
        .i_bist_start (i_bist_start),
        .i_lbist_done (o_lbist_en),
        .i_status     (bist_status),
        .o_bist_en    (bist_en),
        .o_bist_clr   (bist_clr),
        .o_busy       (o_bist_busy),
        .o_done       (o_bist_done),
        .o_result     (o_bist_result)
    );

endmodule

/* verification/hv_analog_model.sv */
// behavioral model of the hv detectors and the adc
// detector flags answer the stimulus lines, adc sample pair every 4 cycles
// per-item fault and stuck masks

module hv_analog_model (
    input  logic                   i_clk,
    input  logic                   i_rst_n,
    input  gd_bist_pkg::bist_vec_t i_stim,
    input  gd_bist_pkg::bist_vec_t i_fault_mask,  // flag never rises
    input  gd_bist_pkg::bist_vec_t i_stuck_mask,  // flag never drops
    input  gd_bist_pkg::adc_data_t i_adc1,
    input  gd_bist_pkg::adc_data_t i_adc2,
    output gd_bist_pkg::hv_flags_t o_flags,
    output gd_bist_pkg::hv_adc_t   o_adc
);

    timeunit 1ns;
    timeprecision 100ps;

    logic [4:0] stim_d1;
    logic [4:0] stim_d2;
    logic [4:0] stuck_q;   // latched once its stimulus was seen
    logic [4:0] flag_vec;  // bit index = item code
    logic [1:0] adc_div;

    // flag held two cycles past the falling stimulus
    always @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            stim_d1 <= '0;
            stim_d2 <= '0;
            stuck_q <= '0;
        end else begin
            stim_d1 <= i_stim[4:0];
            stim_d2 <= stim_d1;
            stuck_q <= (stuck_q | i_stim[4:0]) & i_stuck_mask[4:0];  // drops with the mask
        end
    end

    // asynchronous detectors, short analog response delay
    assign #3 flag_vec = (i_stim[4:0] | stim_d1 | stim_d2 | stuck_q) & ~i_fault_mask[4:0];
    assign o_flags = {flag_vec[0], flag_vec[1], flag_vec[2], flag_vec[3], flag_vec[4]};

    always @(posedge i_clk or negedge i_rst_n) begin
        if (!i_rst_n) begin
            adc_div <= '0;
            o_adc   <= '0;
        end else begin
            adc_div     <= adc_div + 2'd1;
            o_adc.data1 <= i_adc1;
            o_adc.data2 <= i_adc2;
            o_adc.vld   <= (adc_div == 2'd3);  // one strobe per 4 cycles
        end
    end

endmodule

/* verification/hv_bist_tb.sv */
// testbench for the hv-side bist
// scenario table with fault, stuck and adc rows applied in a loop
// stimulus one-hot and pulse length monitor, compare tasks, report

`include "gd_bist_consts.svh"

module hv_bist_tb;

    timeunit 1ns;
    timeprecision 100ps;

    typedef struct packed {
        gd_bist_pkg::bist_vec_t fault;
        gd_bist_pkg::bist_vec_t stuck;
        gd_bist_pkg::adc_data_t adc1;
        gd_bist_pkg::adc_data_t adc2;
        gd_bist_pkg::bist_vec_t exp_status;
        logic                   exp_pass;
        logic                   exp_tmo;
    } row_t;

    logic                      clk = 1'b0;
    logic                      rst_n;
    logic                      bist_start;
    gd_bist_pkg::bist_vec_t    fault_mask;
    gd_bist_pkg::bist_vec_t    stuck_mask;
    gd_bist_pkg::adc_data_t    adc1;
    gd_bist_pkg::adc_data_t    adc2;
    gd_bist_pkg::hv_flags_t    hv_flags;
    gd_bist_pkg::hv_adc_t      hv_adc;
    gd_bist_pkg::bist_vec_t    bist_stim;
    logic                      bist_done;
    logic                      bist_busy;
    logic                      lbist_en;
    gd_bist_pkg::bist_result_t bist_result;
    gd_bist_pkg::bist_cnt_t    pulse_len [6];
    row_t                      rows [$];
    string                     names [$];
    string                     cur_name = "reset";
    int                        errors = 0;
    int                        checks = 0;

    always #5 clk = ~clk;

    hv_bist_top u_hv_bist_top (
        .i_clk         (clk),
        .i_rst_n       (rst_n),
        .i_bist_start  (bist_start),
        .i_hv_flags    (hv_flags),
        .i_hv_adc      (hv_adc),
        .o_bist_stim   (bist_stim),
        .o_bist_done   (bist_done),
        .o_bist_busy   (bist_busy),
        .o_bist_result (bist_result),
        .o_lbist_en    (lbist_en)
    );

    hv_analog_model u_hv_analog_model (
        .i_clk        (clk),
        .i_rst_n      (rst_n),
        .i_stim       (bist_stim),
        .i_fault_mask (fault_mask),
        .i_stuck_mask (stuck_mask),
        .i_adc1       (adc1),
        .i_adc2       (adc2),
        .o_flags      (hv_flags),
        .o_adc        (hv_adc)
    );

    // ==============================
    // compare tasks
    // ==============================
    task automatic check_vec(input string name, input gd_bist_pkg::bist_vec_t exp,
                             input gd_bist_pkg::bist_vec_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error: %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_bit(input string name, input logic exp, input logic act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error: %s expected %b actual %b", name, exp, act);
        end
    endtask

    task automatic check_cnt(input string name, input gd_bist_pkg::bist_cnt_t exp,
                             input gd_bist_pkg::bist_cnt_t act);
        checks++;
        if (act !== exp) begin
            errors++;
            $display("Error: %s expected %0d actual %0d", name, exp, act);
        end
    endtask

    task automatic check_onehot(input string name, input gd_bist_pkg::bist_vec_t act);
        checks++;
        if ((act & (act - 1'b1)) != '0) begin
            errors++;
            $display("more than one stimulus line high in %s, lines %b", name, act);
        end
    endtask

    task automatic add_row(input string name, input gd_bist_pkg::bist_vec_t fault,
                           input gd_bist_pkg::bist_vec_t stuck, input int a1, input int a2,
                           input gd_bist_pkg::bist_vec_t exp_status, input logic exp_pass,
                           input logic exp_tmo);
        row_t r;
        r.fault      = fault;
        r.stuck      = stuck;
        r.adc1       = gd_bist_pkg::adc_data_t'(a1);
        r.adc2       = gd_bist_pkg::adc_data_t'(a2);
        r.exp_status = exp_status;
        r.exp_pass   = exp_pass;
        r.exp_tmo    = exp_tmo;
        rows.push_back(r);
        names.push_back(name);
    endtask

    function automatic gd_bist_pkg::bist_cnt_t exp_pulse(input int item);
        case (item)
            0:       exp_pulse = `WIN_OV_CYC;
            5:       exp_pulse = `WIN_ADC_CYC;
            default: exp_pulse = `WIN_FLT_CYC;
        endcase
    endfunction

    // ==============================
    // stimulus monitor
    // ==============================
    always @(negedge clk) begin : stim_monitor
        int b;
        if (rst_n) begin
            check_onehot({cur_name, " stim"}, bist_stim);
            for (b = 0; b < 6; b++) begin
                if (bist_stim[b]) begin
                    pulse_len[b] = pulse_len[b] + 1'b1;
                end else if (pulse_len[b] != 0) begin  // pulse just ended
                    check_cnt($sformatf("%s stim%0d length", cur_name, b), exp_pulse(b),
                              pulse_len[b]);
                    pulse_len[b] = '0;
                end
            end
        end
    end

    // ==============================
    // scenario loop
    // ==============================
    initial begin : main
        int   i;
        int   wait_cyc;
        logic hung;
        row_t r;
        rst_n      = 1'b0;
        bist_start = 1'b0;
        fault_mask = '0;
        stuck_mask = '0;
        adc1       = 10'd512;
        adc2       = 10'd512;
        hung       = 1'b0;
        foreach (pulse_len[k]) begin
            pulse_len[k] = '0;
        end
        void'($urandom(52506));

        // name, fault, stuck, adc1, adc2, status, pass, timeout
        add_row("clean",       6'h00, 6'h00, 512, 512, 6'h3f, 1'b1, 1'b0);
        add_row("fault_ov",    6'h01, 6'h00, 512, 512, 6'h3e, 1'b0, 1'b0);
        add_row("fault_ot",    6'h02, 6'h00, 512, 512, 6'h3d, 1'b0, 1'b0);
        add_row("fault_desat", 6'h04, 6'h00, 512, 512, 6'h3b, 1'b0, 1'b0);
        add_row("fault_oc",    6'h08, 6'h00, 512, 512, 6'h37, 1'b0, 1'b0);
        add_row("fault_sc",    6'h10, 6'h00, 512, 512, 6'h2f, 1'b0, 1'b0);
        add_row("adc1_low",    6'h00, 6'h00, 503, 512, 6'h1f, 1'b0, 1'b0);
        add_row("adc2_high",   6'h00, 6'h00, 512, 520, 6'h1f, 1'b0, 1'b0);
        add_row("adc_edges",   6'h00, 6'h00, 504, 519, 6'h3f, 1'b1, 1'b0);
        add_row("stuck_desat", 6'h00, 6'h04, 512, 512, 6'h07, 1'b0, 1'b1);
        add_row("clean_again", 6'h00, 6'h00, 512, 512, 6'h3f, 1'b1, 1'b0);
        add_row("stuck_ov",    6'h00, 6'h01, 512, 512, 6'h01, 1'b0, 1'b1);
        add_row("rand_in",     6'h00, 6'h00, `ADC_DN_TH + $urandom % 16,
                `ADC_DN_TH + $urandom % 16, 6'h3f, 1'b1, 1'b0);
        add_row("rand_out",    6'h00, 6'h00, `ADC_DN_TH + $urandom % 16,
                `ADC_UP_TH + 1 + $urandom % 504, 6'h1f, 1'b0, 1'b0);

        repeat (8) @(posedge clk);
        rst_n <= 1'b1;
        @(negedge clk);
        check_vec("reset stim", '0, bist_stim);
        check_bit("reset done", 1'b0, bist_done);
        check_bit("reset busy", 1'b0, bist_busy);
        check_bit("reset lbist_en", 1'b0, lbist_en);
        check_vec("reset status", '0, bist_result.status);
        check_bit("reset pass", 1'b0, bist_result.pass);
        check_bit("reset timeout", 1'b0, bist_result.timeout);

        for (i = 0; i < rows.size() && !hung; i++) begin
            r = rows[i];
            @(posedge clk);
            fault_mask <= r.fault;
            stuck_mask <= r.stuck;
            adc1       <= r.adc1;
            adc2       <= r.adc2;
            cur_name    = names[i];
            repeat (8) @(posedge clk);  // stuck flag of the last row falls back
            bist_start <= 1'b1;
            @(posedge clk);
            bist_start <= 1'b0;
            repeat (20) @(posedge clk);
            bist_start <= 1'b1;  // ignored while the run is going
            @(posedge clk);
            bist_start <= 1'b0;
            @(negedge clk);
            check_bit({cur_name, " busy"}, 1'b1, bist_busy);
            check_vec({cur_name, " cleared status"}, '0, bist_result.status);
            check_bit({cur_name, " cleared pass"}, 1'b0, bist_result.pass);
            check_bit({cur_name, " cleared timeout"}, 1'b0, bist_result.timeout);
            wait_cyc = 0;
            while (!bist_done && wait_cyc < `BIST_TIMEOUT_CYC + 200) begin
                @(negedge clk);
                wait_cyc++;
            end
            if (!bist_done) begin
                hung = 1'b1;
                errors++;
                $display("no done from the DUT within the run limit in row %s", cur_name);
            end else begin
                check_vec({cur_name, " status"}, r.exp_status, bist_result.status);
                check_bit({cur_name, " pass"}, r.exp_pass, bist_result.pass);
                check_bit({cur_name, " timeout"}, r.exp_tmo, bist_result.timeout);
                check_bit({cur_name, " lbist_en"}, !r.exp_tmo, lbist_en);
            end
        end

        $display("checks: %0d  errors: %0d", checks, errors);
        if (errors == 0 && !hung) begin
            $display("test passed");
        end else begin
            $display("test failed");
        end
        $finish;
    end

endmodule

/* sources.f */
+incdir+src
src/gd_bist_pkg.sv
src/hv_flag_sync.sv
src/hv_abist.sv
src/bist_ctrl.sv
src/hv_bist_top.sv
verification/hv_analog_model.sv
verification/hv_bist_tb.sv

/* Bender.yml */
package:
  name: hv_bist

export_include_dirs:
  - src

sources:
  - src/gd_bist_pkg.sv
  - src/hv_flag_sync.sv
  - src/hv_abist.sv
  - src/bist_ctrl.sv
  - src/hv_bist_top.sv
  - target: simulation
    files:
      - verification/hv_analog_model.sv
      - verification/hv_bist_tb.sv
